/* include/fp_core_macros.svh */
`ifndef FP_CORE_MACROS_SVH
`define FP_CORE_MACROS_SVH

// data path width, single precision only
`define FP_XLEN 32

// architectural float registers f0..f31
`define FP_REG_COUNT 32

// quiet NaN with the payload cleared
`define FP_CANONICAL_NAN 32'h7fc00000

`endif

/* source/fp_pkg.sv */
`default_nettype none

`include "fp_core_macros.svh"

package fp_pkg;

  typedef logic [`FP_XLEN-1:0] fp_word_t;                  // float bits or integer value
  typedef logic [$clog2(`FP_REG_COUNT)-1:0] fp_reg_addr_t;
  typedef logic [4:0] fp_flags_t;                          // nv dz of uf nx

  ////////////////////////////////////////
  // operations kept from the F extension
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    fp_op_none,                                            // undecodable word
    fp_op_sgnj,
    fp_op_sgnjn,
    fp_op_sgnjx,
    fp_op_min,
    fp_op_max,
    fp_op_eq,
    fp_op_lt,
    fp_op_le,
    fp_op_mv_f2i,                                          // fmv.x.w
    fp_op_mv_i2f,                                          // fmv.w.x
    fp_op_class
  } fp_op_e;

endpackage

`default_nettype wire

/* source/fp_stage_if.sv */
`default_nettype none

interface fp_stage_if;
  import fp_pkg::*;

  logic         valid;
  fp_op_e       op;
  fp_reg_addr_t rd;
  fp_reg_addr_t rs1;
  fp_reg_addr_t rs2;
  logic         int_dest;    // result leaves for the integer side
  logic         uses_rs1;
  logic         uses_rs2;
  fp_word_t     operand_a;
  fp_word_t     operand_b;
  fp_word_t     result;
  fp_flags_t    flags;

  modport producer (
    output valid, op, rd, rs1, rs2, int_dest, uses_rs1, uses_rs2,
    output operand_a, operand_b, result, flags
  );

  modport consumer (
    input valid, op, rd, rs1, rs2, int_dest, uses_rs1, uses_rs2,
    input operand_a, operand_b, result, flags
  );

endinterface

`default_nettype wire

/* source/fp_decode.sv */
`default_nettype none

module fp_decode (
  input  wire logic            clock,
  input  wire logic            reset,
  input  wire fp_pkg::fp_word_t instr_i,
  input  wire logic            instr_valid_i,
  input  wire fp_pkg::fp_word_t int_data_i,
  output logic                 illegal_o,
  fp_stage_if.producer         stage_o
);
  import fp_pkg::*;

  localparam logic [6:0] opcode_fp     = 7'b1010011;
  localparam logic [4:0] funct_sgnj    = 5'b00100;
  localparam logic [4:0] funct_minmax  = 5'b00101;
  localparam logic [4:0] funct_cmp     = 5'b10100;
  localparam logic [4:0] funct_mv_f2i  = 5'b11100;   // shared with fclass
  localparam logic [4:0] funct_mv_i2f  = 5'b11110;

  fp_op_e     dec_op;
  logic       dec_int_dest;
  logic       dec_uses_rs1;
  logic       dec_uses_rs2;
  logic [2:0] rm;
  logic [2:0] illegal_q;

  assign rm = instr_i[14:12];

  ////////////////////////////////////////
  // field decode
  ////////////////////////////////////////

  always_comb begin
    dec_op       = fp_op_none;
    dec_int_dest = 1'b0;
    dec_uses_rs1 = 1'b0;
    dec_uses_rs2 = 1'b0;
    if (instr_i[6:0] == opcode_fp && instr_i[26:25] == 2'b00) begin   // fmt must be S
      case (instr_i[31:27])
        funct_sgnj: begin
          dec_uses_rs1 = 1'b1;
          dec_uses_rs2 = 1'b1;
          case (rm)
            3'b000:  dec_op = fp_op_sgnj;
            3'b001:  dec_op = fp_op_sgnjn;
            3'b010:  dec_op = fp_op_sgnjx;
            default: dec_op = fp_op_none;
          endcase
        end
        funct_minmax: begin
          dec_uses_rs1 = 1'b1;
          dec_uses_rs2 = 1'b1;
          case (rm)
            3'b000:  dec_op = fp_op_min;
            3'b001:  dec_op = fp_op_max;
            default: dec_op = fp_op_none;
          endcase
        end
        funct_cmp: begin
          dec_int_dest = 1'b1;
          dec_uses_rs1 = 1'b1;
          dec_uses_rs2 = 1'b1;
          case (rm)
            3'b010:  dec_op = fp_op_eq;
            3'b001:  dec_op = fp_op_lt;
            3'b000:  dec_op = fp_op_le;
            default: dec_op = fp_op_none;
          endcase
        end
        funct_mv_f2i: begin
          dec_int_dest = 1'b1;
          dec_uses_rs1 = 1'b1;
          if (instr_i[24:20] == 5'd0 && rm == 3'b000) dec_op = fp_op_mv_f2i;
          else if (instr_i[24:20] == 5'd0 && rm == 3'b001) dec_op = fp_op_class;
        end
        funct_mv_i2f: begin
          if (instr_i[24:20] == 5'd0 && rm == 3'b000) dec_op = fp_op_mv_i2f;
        end
        default: dec_op = fp_op_none;
      endcase
    end
  end

  ////////////////////////////////////////
  // decode register
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      stage_o.valid <= 1'b0;
      illegal_q     <= '0;
    end else begin
      stage_o.valid <= instr_valid_i;
      illegal_q     <= {illegal_q[1:0], instr_valid_i && dec_op == fp_op_none};
    end
  end

  always_ff @(posedge clock) begin
    stage_o.op        <= dec_op;
    stage_o.rd        <= instr_i[11:7];
    stage_o.rs1       <= instr_i[19:15];
    stage_o.rs2       <= instr_i[24:20];
    stage_o.int_dest  <= dec_int_dest;
    stage_o.uses_rs1  <= dec_uses_rs1;
    stage_o.uses_rs2  <= dec_uses_rs2;
    stage_o.operand_a <= int_data_i;    // only kept when rs1 is not read
  end

  assign stage_o.operand_b = '0;
  assign stage_o.result    = '0;
  assign stage_o.flags     = '0;

  assign illegal_o = illegal_q[2];      // lines up with result_valid_o

  // an undecodable word must surface on illegal_o two cycles later
  assert property (@(posedge clock) disable iff (!reset)
    (stage_o.valid && stage_o.op == fp_op_none) |-> ##2 illegal_o);

endmodule

`default_nettype wire

/* source/fp_operand_read.sv */
`default_nettype none

`include "fp_core_macros.svh"

module fp_operand_read (
  input  wire logic    clock,
  input  wire logic    reset,
  fp_stage_if.consumer stage_i,
  fp_stage_if.consumer execute_i,
  fp_stage_if.consumer writeback_i,
  fp_stage_if.producer stage_o
);
  import fp_pkg::*;

  fp_word_t reg_file [`FP_REG_COUNT];
  fp_word_t operand_a;
  fp_word_t operand_b;
  logic     exe_writes_f;
  logic     wb_writes_f;

  assign exe_writes_f = execute_i.valid && !execute_i.int_dest && execute_i.op != fp_op_none;
  assign wb_writes_f  = writeback_i.valid && !writeback_i.int_dest
                        && writeback_i.op != fp_op_none;

  // youngest producer first, then the one retiring, then the file
  function automatic fp_word_t forward_value(input fp_reg_addr_t addr);
    if (exe_writes_f && execute_i.rd == addr) return execute_i.result;
    else if (wb_writes_f && writeback_i.rd == addr) return writeback_i.result;
    else return reg_file[addr];
  endfunction

  always_comb begin
    operand_a = stage_i.uses_rs1 ? forward_value(stage_i.rs1) : stage_i.operand_a;
    operand_b = stage_i.uses_rs2 ? forward_value(stage_i.rs2) : stage_i.operand_b;
  end

  ////////////////////////////////////////
  // float register file
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `FP_REG_COUNT; i++) reg_file[i] <= '0;
    end else if (wb_writes_f) begin
      reg_file[writeback_i.rd] <= writeback_i.result;   // end of writeback
    end
  end

  ////////////////////////////////////////
  // read stage register
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) stage_o.valid <= 1'b0;
    else stage_o.valid <= stage_i.valid;
  end

  always_ff @(posedge clock) begin
    stage_o.op        <= stage_i.op;
    stage_o.rd        <= stage_i.rd;
    stage_o.rs1       <= stage_i.rs1;
    stage_o.rs2       <= stage_i.rs2;
    stage_o.int_dest  <= stage_i.int_dest;
    stage_o.uses_rs1  <= stage_i.uses_rs1;
    stage_o.uses_rs2  <= stage_i.uses_rs2;
    stage_o.operand_a <= operand_a;
    stage_o.operand_b <= operand_b;
    stage_o.result    <= stage_i.result;
    stage_o.flags     <= stage_i.flags;
  end

endmodule

`default_nettype wire

/* source/fp_execute.sv */
`default_nettype none

`include "fp_core_macros.svh"

module fp_execute (
  input  wire logic    clock,
  input  wire logic    reset,
  fp_stage_if.consumer stage_i,
  fp_stage_if.producer forward_o,
  fp_stage_if.producer stage_o
);
  import fp_pkg::*;

  fp_word_t a;
  fp_word_t b;
  fp_word_t result;
  logic     invalid;
  logic     a_nan, b_nan, a_snan, b_snan, any_nan;
  logic     both_zero;
  logic     lt_ordered;   // -0 below +0, for min/max
  logic     lt_ieee;      // -0 equal to +0, for flt/fle
  logic     eq_ieee;

  function automatic logic is_nan(input fp_word_t x);
    return x[30:23] == 8'hff && x[22:0] != '0;
  endfunction

  function automatic logic [9:0] classify(input fp_word_t x);
    logic [7:0]  exp;
    logic [22:0] man;
    logic [9:0]  mask;
    exp  = x[30:23];
    man  = x[22:0];
    mask = '0;
    if (exp == 8'hff) begin
      if (man == '0) mask[x[31] ? 0 : 7] = 1'b1;            // infinities
      else if (man[22]) mask[9] = 1'b1;                     // quiet
      else mask[8] = 1'b1;
    end else if (exp == 8'h00) begin
      if (man == '0) mask[x[31] ? 3 : 4] = 1'b1;
      else mask[x[31] ? 2 : 5] = 1'b1;                      // subnormal
    end else begin
      mask[x[31] ? 1 : 6] = 1'b1;
    end
    return mask;
  endfunction

  assign a         = stage_i.operand_a;
  assign b         = stage_i.operand_b;
  assign a_nan     = is_nan(a);
  assign b_nan     = is_nan(b);
  assign a_snan    = a_nan && !a[22];
  assign b_snan    = b_nan && !b[22];
  assign any_nan   = a_nan || b_nan;
  assign both_zero = a[30:0] == '0 && b[30:0] == '0;
  assign eq_ieee   = a == b || both_zero;

  always_comb begin
    if (a[31] != b[31]) begin
      lt_ordered = a[31];
      lt_ieee    = a[31] && !both_zero;
    end else begin
      lt_ordered = a[31] ? a[30:0] > b[30:0] : a[30:0] < b[30:0];   // magnitude flips
      lt_ieee    = lt_ordered;
    end
  end

  ////////////////////////////////////////
  // result select
  ////////////////////////////////////////

  always_comb begin
    result  = '0;
    invalid = 1'b0;
    case (stage_i.op)
      fp_op_sgnj:  result = {b[31], a[30:0]};
      fp_op_sgnjn: result = {~b[31], a[30:0]};
      fp_op_sgnjx: result = {a[31] ^ b[31], a[30:0]};
      fp_op_min, fp_op_max: begin
        invalid = a_snan || b_snan;
        if (a_nan && b_nan) result = `FP_CANONICAL_NAN;
        else if (a_nan) result = b;
        else if (b_nan) result = a;
        else if ((stage_i.op == fp_op_min) == lt_ordered) result = a;
        else result = b;
      end
      fp_op_eq: begin
        invalid = a_snan || b_snan;                           // quiet compare
        result  = fp_word_t'(!any_nan && eq_ieee);
      end
      fp_op_lt: begin
        invalid = any_nan;
        result  = fp_word_t'(!any_nan && lt_ieee);
      end
      fp_op_le: begin
        invalid = any_nan;
        result  = fp_word_t'(!any_nan && (lt_ieee || eq_ieee));
      end
      fp_op_mv_f2i, fp_op_mv_i2f: result = a;
      fp_op_class: result = fp_word_t'(classify(a));
      default: result = '0;
    endcase
  end

  assign forward_o.valid     = stage_i.valid;
  assign forward_o.op        = stage_i.op;
  assign forward_o.rd        = stage_i.rd;
  assign forward_o.rs1       = stage_i.rs1;
  assign forward_o.rs2       = stage_i.rs2;
  assign forward_o.int_dest  = stage_i.int_dest;
  assign forward_o.uses_rs1  = stage_i.uses_rs1;
  assign forward_o.uses_rs2  = stage_i.uses_rs2;
  assign forward_o.operand_a = a;
  assign forward_o.operand_b = b;
  assign forward_o.result    = result;
  assign forward_o.flags     = {invalid, 4'b0000};         // only nv is ever raised

  ////////////////////////////////////////
  // execute register
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) stage_o.valid <= 1'b0;
    else stage_o.valid <= forward_o.valid;
  end

  always_ff @(posedge clock) begin
    stage_o.op        <= forward_o.op;
    stage_o.rd        <= forward_o.rd;
    stage_o.rs1       <= forward_o.rs1;
    stage_o.rs2       <= forward_o.rs2;
    stage_o.int_dest  <= forward_o.int_dest;
    stage_o.uses_rs1  <= forward_o.uses_rs1;
    stage_o.uses_rs2  <= forward_o.uses_rs2;
    stage_o.operand_a <= forward_o.operand_a;
    stage_o.operand_b <= forward_o.operand_b;
    stage_o.result    <= forward_o.result;
    stage_o.flags     <= forward_o.flags;
  end

  assert property (@(posedge clock) disable iff (!reset)
    (stage_o.valid && stage_o.op == fp_op_class) |-> $onehot(stage_o.result));

endmodule

`default_nettype wire

/* source/fp_writeback.sv */
`default_nettype none

module fp_writeback (
  input  wire logic                 clock,
  input  wire logic                 reset,
  fp_stage_if.consumer              stage_i,
  input  wire logic                 fflags_clear_i,
  output logic                      result_valid_o,
  output fp_pkg::fp_word_t          result_o,
  output fp_pkg::fp_reg_addr_t      result_rd_o,
  output logic                      result_int_o,
  output fp_pkg::fp_flags_t         fflags_o
);
  import fp_pkg::*;

  fp_flags_t raised;

  // illegal words retire silently
  assign result_valid_o = stage_i.valid && stage_i.op != fp_op_none;
  assign result_o       = stage_i.result;
  assign result_rd_o    = stage_i.rd;
  assign result_int_o   = stage_i.int_dest;

  assign raised = stage_i.valid ? stage_i.flags : '0;

  // a new flag in the clear cycle survives the clear
  always_ff @(posedge clock) begin
    if (!reset) fflags_o <= '0;
    else if (fflags_clear_i) fflags_o <= raised;
    else fflags_o <= fflags_o | raised;
  end

endmodule

`default_nettype wire

/* source/fp_core.sv */
`default_nettype none

module fp_core (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire fp_pkg::fp_word_t     instr_i,
  input  wire logic                 instr_valid_i,
  input  wire fp_pkg::fp_word_t     int_data_i,
  input  wire logic                 fflags_clear_i,
  output logic                      result_valid_o,
  output fp_pkg::fp_word_t          result_o,
  output fp_pkg::fp_reg_addr_t      result_rd_o,
  output logic                      result_int_o,
  output logic                      illegal_o,
  output fp_pkg::fp_flags_t         fflags_o
);

  fp_stage_if decode_to_read ();
  fp_stage_if read_to_execute ();
  fp_stage_if execute_to_writeback ();
  fp_stage_if execute_forward ();     // live execute result

  fp_decode u_decode (
    .clock         (clock),
    .reset         (reset),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .int_data_i    (int_data_i),
    .illegal_o     (illegal_o),
    .stage_o       (decode_to_read.producer)
  );

  fp_operand_read u_operand_read (
    .clock       (clock),
    .reset       (reset),
    .stage_i     (decode_to_read.consumer),
    .execute_i   (execute_forward.consumer),
    .writeback_i (execute_to_writeback.consumer),
    .stage_o     (read_to_execute.producer)
  );

  fp_execute u_execute (
    .clock     (clock),
    .reset     (reset),
    .stage_i   (read_to_execute.consumer),
    .forward_o (execute_forward.producer),
    .stage_o   (execute_to_writeback.producer)
  );

  fp_writeback u_writeback (
    .clock          (clock),
    .reset          (reset),
    .stage_i        (execute_to_writeback.consumer),
    .fflags_clear_i (fflags_clear_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_rd_o    (result_rd_o),
    .result_int_o   (result_int_o),
    .fflags_o       (fflags_o)
  );

endmodule

`default_nettype wire

/* bench/fp_core_tb.sv */
`default_nettype none

`include "fp_core_macros.svh"

module fp_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clock;
  logic        reset;
  logic [31:0] instr_i;
  logic        instr_valid_i;
  logic [31:0] int_data_i;
  logic        fflags_clear_i;
  logic        result_valid_o;
  logic [31:0] result_o;
  logic [4:0]  result_rd_o;
  logic        result_int_o;
  logic        illegal_o;
  logic [4:0]  fflags_o;

  logic [31:0] shadow [`FP_REG_COUNT];     // architectural float registers, in program order
  string       exp_name [$];
  logic [31:0] exp_value [$];
  logic        exp_int [$];
  logic [4:0]  exp_rd [$];
  logic        exp_nv [$];
  int unsigned exp_due [$];
  int unsigned illegal_due [$];
  int unsigned cycle_count;
  int unsigned tests;
  int unsigned checks;
  int unsigned errors;
  string       test_name;
  logic [4:0]  model_flags;

  // captured at the falling edge, checked by the assertions at the next rising edge
  logic        chk_result;
  logic        chk_unexpected;
  logic        chk_late;
  string       chk_name;
  logic [31:0] chk_value_exp;
  logic [31:0] chk_value_act;
  logic        chk_int_exp;
  logic        chk_int_act;
  logic [4:0]  chk_rd_exp;
  logic [4:0]  chk_rd_act;
  int unsigned chk_due;
  int unsigned chk_cycle;
  logic        chk_illegal_exp;
  logic        chk_illegal_act;
  logic [4:0]  chk_flags_exp;
  logic [4:0]  chk_flags_act;

  fp_core dut (
    .clock          (clock),
    .reset          (reset),
    .instr_i        (instr_i),
    .instr_valid_i  (instr_valid_i),
    .int_data_i     (int_data_i),
    .fflags_clear_i (fflags_clear_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_rd_o    (result_rd_o),
    .result_int_o   (result_int_o),
    .illegal_o      (illegal_o),
    .fflags_o       (fflags_o)
  );

  always #2 clock = ~clock;

  ////////////////////////////////////////
  // reference helpers
  ////////////////////////////////////////

  function automatic logic nan_of(input logic [31:0] x);
    return (x & 32'h7fffffff) > 32'h7f800000;
  endfunction

  function automatic logic signaling_of(input logic [31:0] x);
    return nan_of(x) && !x[22];
  endfunction

  // unsigned key that sorts floats, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h80000000);
  endfunction

  function automatic logic [31:0] encode(input logic [4:0] funct5, input logic [2:0] rm,
                                         input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [4:0] rd);
    return {funct5, 2'b00, rs2, rs1, rm, rd, 7'b1010011};
  endfunction

  // one operand of class idx, in fclass bit order
  function automatic logic [31:0] class_sample(input int idx);
    logic [22:0] man;
    logic [7:0]  expo;
    man  = 23'($urandom) | 23'd1;
    expo = 8'($urandom_range(1, 254));
    case (idx)
      0: return 32'hff800000;
      1: return {1'b1, expo, man};
      2: return {9'h100, man};
      3: return 32'h80000000;
      4: return 32'h00000000;
      5: return {9'h000, man};
      6: return {1'b0, expo, man};
      7: return 32'h7f800000;
      8: return {9'h0ff, 1'b0, man[21:0] | 22'd1};
      default: return {9'h0ff, 1'b1, man[21:0]};
    endcase
  endfunction

  function automatic logic [31:0] undecodable_word();
    logic [31:0] word;
    word = $urandom;
    if (word[0]) begin
      word[6:0] = 7'b0110011;                 // integer register op
    end else begin
      word[6:0]   = 7'b1010011;
      word[31:27] = 5'($urandom_range(0, 3)); // fadd..fdiv, not kept
    end
    return word;
  endfunction

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  task automatic send(input logic [31:0] word, input logic [31:0] data, input logic legal,
                      input logic [31:0] value, input logic to_int, input logic [4:0] rd,
                      input logic nv);
    @(posedge clock);
    instr_i       <= word;
    instr_valid_i <= 1'b1;
    int_data_i    <= data;
    if (legal) begin
      exp_name.push_back(test_name);
      exp_value.push_back(value);
      exp_int.push_back(to_int);
      exp_rd.push_back(rd);
      exp_nv.push_back(nv);
      exp_due.push_back(cycle_count + 3);
    end else begin
      illegal_due.push_back(cycle_count + 3);
    end
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    send(encode(5'b11110, 3'b000, 5'd0, 5'd0, rd), value, 1'b1, value, 1'b0, rd, 1'b0);
    shadow[rd] = value;
  endtask

  task automatic read_reg(input logic [4:0] rd, input logic [4:0] rs);
    send(encode(5'b11100, 3'b000, 5'd0, rs, rd), $urandom, 1'b1, shadow[rs], 1'b1, rd, 1'b0);
  endtask

  task automatic sign_inject(input logic [1:0] kind, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    logic        sign;
    a = shadow[rs1];
    b = shadow[rs2];
    case (kind)
      2'd0:    sign = b[31];
      2'd1:    sign = ~b[31];
      default: sign = a[31] ^ b[31];
    endcase
    send(encode(5'b00100, {1'b0, kind}, rs2, rs1, rd), $urandom, 1'b1, {sign, a[30:0]},
         1'b0, rd, 1'b0);
    shadow[rd] = {sign, a[30:0]};
  endtask

  task automatic min_max(input logic is_max, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    a = shadow[rs1];
    b = shadow[rs2];
    if (nan_of(a) && nan_of(b)) value = `FP_CANONICAL_NAN;
    else if (nan_of(a)) value = b;
    else if (nan_of(b)) value = a;
    else if ((order_key(a) < order_key(b)) != is_max) value = a;
    else value = b;
    send(encode(5'b00101, {2'b00, is_max}, rs2, rs1, rd), $urandom, 1'b1, value, 1'b0, rd,
         signaling_of(a) || signaling_of(b));
    shadow[rd] = value;
  endtask

  // kind 0 feq, 1 flt, 2 fle
  task automatic compare(input logic [1:0] kind, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    logic        any_nan;
    logic        zeros;
    logic        equal;
    logic        less;
    logic        hit;
    logic        nv;
    logic [2:0]  rm;
    a       = shadow[rs1];
    b       = shadow[rs2];
    any_nan = nan_of(a) || nan_of(b);
    zeros   = (a << 1) == '0 && (b << 1) == '0;
    equal   = a == b || zeros;
    less    = !zeros && order_key(a) < order_key(b);
    case (kind)
      2'd0: begin
        rm  = 3'b010;
        hit = equal;
        nv  = signaling_of(a) || signaling_of(b);
      end
      2'd1: begin
        rm  = 3'b001;
        hit = less;
        nv  = any_nan;
      end
      default: begin
        rm  = 3'b000;
        hit = less || equal;
        nv  = any_nan;
      end
    endcase
    send(encode(5'b10100, rm, rs2, rs1, rd), $urandom, 1'b1, {31'd0, hit && !any_nan},
         1'b1, rd, nv);
  endtask

  task automatic class_query(input logic [4:0] rd, input logic [4:0] rs, input logic [31:0] mask);
    send(encode(5'b11100, 3'b001, 5'd0, rs, rd), $urandom, 1'b1, mask, 1'b1, rd, 1'b0);
  endtask

  task automatic clear_flags();
    @(posedge clock);
    instr_valid_i  <= 1'b0;
    fflags_clear_i <= 1'b1;
    @(posedge clock);
    fflags_clear_i <= 1'b0;
  endtask

  task automatic drain();
    int unsigned waited;
    @(posedge clock);
    instr_valid_i  <= 1'b0;
    fflags_clear_i <= 1'b0;
    waited = 0;
    while ((exp_due.size() != 0 || illegal_due.size() != 0) && waited < 64) begin
      @(posedge clock);
      waited++;
    end
    if (exp_due.size() != 0 || illegal_due.size() != 0) begin
      $display("%s: timed out with %0d results and %0d illegal pulses still missing",
               test_name, exp_due.size(), illegal_due.size());
      errors++;
      exp_name.delete();
      exp_value.delete();
      exp_int.delete();
      exp_rd.delete();
      exp_nv.delete();
      exp_due.delete();
      illegal_due.delete();
    end
    repeat (2) @(posedge clock);  // lets the last flag update get checked
  endtask

  task automatic finish_test();
    drain();
    tests++;
    $display("%s finished, %0d errors so far", test_name, errors);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic reset_state();
    test_name = "reset_state";
    for (int i = 0; i < `FP_REG_COUNT; i++) read_reg(5'($urandom), 5'(i));
    finish_test();
  endtask

  task automatic load_readback();
    test_name = "load_readback";
    for (int i = 0; i < `FP_REG_COUNT; i++) load_reg(5'(i), $urandom);
    for (int i = 0; i < `FP_REG_COUNT; i++) read_reg(5'(i), 5'(i));
    finish_test();
  endtask

  task automatic forwarding();
    logic [4:0] r;
    test_name = "forwarding";
    for (int d = 1; d <= 3; d++) begin
      repeat (8) begin
        r = 5'($urandom_range(1, 7));
        sign_inject(2'($urandom_range(0, 2)), r, 5'($urandom_range(0, 7)),
                    5'($urandom_range(0, 7)));
        repeat (d - 1) read_reg(5'd1, 5'd31);   // int dest, leaves f regs alone
        if ($urandom_range(0, 1) == 1)
          sign_inject(2'($urandom_range(0, 2)), 5'($urandom_range(0, 7)), r,
                      5'($urandom_range(0, 7)));
        else
          sign_inject(2'($urandom_range(0, 2)), 5'($urandom_range(0, 7)),
                      5'($urandom_range(0, 7)), r);
      end
    end
    repeat (24) begin
      if ($urandom_range(0, 1) == 1)
        sign_inject(2'($urandom_range(0, 2)), 5'($urandom_range(0, 3)),
                    5'($urandom_range(0, 3)), 5'($urandom_range(0, 3)));
      else
        min_max(1'($urandom_range(0, 1)), 5'($urandom_range(0, 3)),
                5'($urandom_range(0, 3)), 5'($urandom_range(0, 3)));
    end
    finish_test();
  endtask

  task automatic minmax_compare();
    test_name = "minmax_compare";
    load_reg(5'd8, {1'b0, 8'($urandom_range(1, 254)), 23'($urandom)});
    load_reg(5'd9, {1'b1, 8'($urandom_range(1, 254)), 23'($urandom)});
    load_reg(5'd10, 32'h00000000);
    load_reg(5'd11, 32'h80000000);
    load_reg(5'd12, 32'h7fc00000 | 32'($urandom_range(0, 255)));
    load_reg(5'd13, 32'h7f800001 | 32'($urandom_range(0, 255)));
    load_reg(5'd14, 32'h7f800000);
    load_reg(5'd15, 32'hff800000);
    load_reg(5'd16, 32'h3f800000);
    load_reg(5'd17, 32'hbf800000);
    repeat (48) begin
      if ($urandom_range(0, 2) == 0)
        min_max(1'($urandom_range(0, 1)), 5'($urandom_range(18, 21)),
                5'($urandom_range(8, 17)), 5'($urandom_range(8, 17)));
      else
        compare(2'($urandom_range(0, 2)), 5'($urandom),
                5'($urandom_range(8, 17)), 5'($urandom_range(8, 17)));
      fflags_clear_i <= ($urandom_range(0, 7) == 0);
    end
    compare(2'd1, 5'd3, 5'd12, 5'd16);   // quiet NaN in flt still raises nv
    drain();
    clear_flags();
    finish_test();
  endtask

  task automatic fclass_masks();
    test_name = "fclass_masks";
    for (int i = 0; i < 10; i++) load_reg(5'(22 + i), class_sample(i));
    for (int i = 0; i < 10; i++) class_query(5'(i + 1), 5'(22 + i), 32'd1 << i);
    finish_test();
  endtask

  task automatic undecodable();
    test_name = "undecodable";
    repeat (12) send(undecodable_word(), $urandom, 1'b0, '0, 1'b0, '0, 1'b0);
    for (int i = 0; i < `FP_REG_COUNT; i++) read_reg(5'($urandom), 5'(i));
    finish_test();
  endtask

  ////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////

  always @(negedge clock) begin : scoreboard
    logic raised;
    raised          = 1'b0;
    chk_result      = 1'b0;
    chk_unexpected  = 1'b0;
    chk_late        = 1'b0;
    chk_illegal_exp = 1'b0;
    chk_illegal_act = illegal_o;
    chk_flags_exp   = model_flags;
    chk_flags_act   = fflags_o;
    if (!reset) begin
      model_flags = '0;
    end else begin
      if (result_valid_o) begin
        if (exp_due.size() == 0) begin
          chk_unexpected = 1'b1;
        end else begin
          chk_name      = exp_name.pop_front();
          chk_value_exp = exp_value.pop_front();
          chk_int_exp   = exp_int.pop_front();
          chk_rd_exp    = exp_rd.pop_front();
          chk_due       = exp_due.pop_front();
          raised        = exp_nv.pop_front();
          chk_value_act = result_o;
          chk_int_act   = result_int_o;
          chk_rd_act    = result_rd_o;
          chk_cycle     = cycle_count;
          chk_result    = 1'b1;
          checks++;
        end
      end else if (exp_due.size() != 0 && exp_due[0] < cycle_count) begin
        chk_late = 1'b1;                  // drop it so later results line up again
        chk_name = exp_name.pop_front();
        exp_value.delete(0);
        exp_int.delete(0);
        exp_rd.delete(0);
        exp_nv.delete(0);
        exp_due.delete(0);
      end
      if (illegal_due.size() != 0 && illegal_due[0] == cycle_count) begin
        chk_illegal_exp = 1'b1;
        illegal_due.delete(0);
      end
      model_flags = (fflags_clear_i ? 5'd0 : model_flags) | {raised, 4'b0000};
    end
    cycle_count <= cycle_count + 1;
  end

  assert property (@(posedge clock) disable iff (!reset)
    chk_result |-> chk_value_act == chk_value_exp)
    else begin
      $display("Error %s: result expected %h actual %h", chk_name, chk_value_exp, chk_value_act);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset)
    chk_result |-> chk_int_act == chk_int_exp && chk_rd_act == chk_rd_exp)
    else begin
      $display("Error %s: int/rd expected %b/%0d actual %b/%0d", chk_name, chk_int_exp,
               chk_rd_exp, chk_int_act, chk_rd_act);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) chk_result |-> chk_cycle == chk_due)
    else begin
      $display("Error %s: result cycle expected %0d actual %0d", chk_name, chk_due, chk_cycle);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) !chk_unexpected)
    else begin
      $display("%s: a result came out with no instruction waiting for it", test_name);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) !chk_late)
    else begin
      $display("%s: an expected result never appeared on time", chk_name);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) chk_illegal_act == chk_illegal_exp)
    else begin
      $display("Error %s: illegal expected %b actual %b", test_name, chk_illegal_exp,
               chk_illegal_act);
      errors++;
    end

  assert property (@(posedge clock) disable iff (!reset) chk_flags_act == chk_flags_exp)
    else begin
      $display("Error %s: fflags expected %b actual %b", test_name, chk_flags_exp, chk_flags_act);
      errors++;
    end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : stimulus
    clock           = 1'b0;
    reset           = 1'b0;
    instr_i         = '0;
    instr_valid_i   = 1'b0;
    int_data_i      = '0;
    fflags_clear_i  = 1'b0;
    cycle_count     = 0;
    tests           = 0;
    checks          = 0;
    errors          = 0;
    model_flags     = '0;
    chk_result      = 1'b0;
    chk_unexpected  = 1'b0;
    chk_late        = 1'b0;
    chk_illegal_exp = 1'b0;
    chk_illegal_act = 1'b0;
    chk_flags_exp   = '0;
    chk_flags_act   = '0;
    test_name       = "reset";
    for (int i = 0; i < `FP_REG_COUNT; i++) shadow[i] = '0;
    void'($urandom(32815));
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    reset_state();
    load_readback();
    forwarding();
    minmax_compare();
    fclass_masks();
    undecodable();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fp_core.f */
+incdir+include
source/fp_pkg.sv
source/fp_stage_if.sv
source/fp_decode.sv
source/fp_operand_read.sv
source/fp_execute.sv
source/fp_writeback.sv
source/fp_core.sv
bench/fp_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fp_core_tb
FILELIST  ?= fp_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)

check: run
	@grep -qx 'No errors' $(LOG) || (echo "simulation reported failures, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
